// File: flist.f
design/cae_isa_pkg.sv
design/cae_reg_pkg.sv
design/instdec.sv
design/aeg_regfile.sv
design/cae_status_apb.sv
design/cae_top.sv
verification/instdec_chk.sv
verification/tb_cae_top.sv

// File: Makefile
TOOL  = verilator
FLAGS = --timing --assert
TOP   = tb_cae_top
FLIST = flist.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

// File: verification/tb_cae_top.sv
// CAE front end testbench: directed AEG, CAEP, exception, APB and idle tests
`timescale 1ns/1ns

module tb_cae_top
  import cae_isa_pkg::*;
  import cae_reg_pkg::*;
();

  localparam int AEG_CNT    = 16;
  localparam int CLK_PERIOD = 8;
  localparam int RESET_CYC  = 16;
  // Summed cycle count of all tests, and some slack on top
  localparam int TEST_CYC   = 340;
  localparam int MARGIN_CYC = 160;

  logic      clk;
  logic      reset;
  inst_t     inst;
  cae_data_t data;
  logic      inst_vld;
  logic      caep_vld;
  caep_t     caep;
  cae_data_t rd_data;
  logic      rd_vld;
  apb_req_t  apb_req;
  apb_rsp_t  apb_rsp;
  logic      irq;

  // Expected AEG contents
  cae_data_t model [AEG_CNT] = '{default: '0};
  int        err_cnt;
  int        chk_cnt;
  int        test_cnt;

  cae_top #(
    .AEG_CNT (AEG_CNT)
  ) dut_i (
    .clk      (clk),
    .reset    (reset),
    .inst     (inst),
    .data     (data),
    .inst_vld (inst_vld),
    .caep_vld (caep_vld),
    .caep     (caep),
    .rd_data  (rd_data),
    .rd_vld   (rd_vld),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .irq      (irq)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #((TEST_CYC + MARGIN_CYC) * CLK_PERIOD);
    $display("Watchdog timeout: tests did not finish in %0d cycles", TEST_CYC + MARGIN_CYC);
    $display("** FAIL **");
    $finish;
  end

  task automatic check(input cae_data_t got, input cae_data_t exp, input string what);
    chk_cnt++;
    assert (got === exp) else begin
      $display("ERROR @%0t: %s got %0h expected %0h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    chk_cnt++;
    assert (got === exp) else begin
      $display("ERROR @%0t: %s got %b expected %b", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report(input string name, input int start);
    test_cnt++;
    $display("%s done, %0d errors", name, err_cnt - start);
  endtask

  // One instruction valid for one cycle, ends on the next falling edge
  task automatic issue(input inst_t i, input cae_data_t d);
    @(negedge clk);
    inst     = i;
    data     = d;
    inst_vld = 1'b1;
    @(negedge clk);
    inst_vld = 1'b0;
  endtask

  // Setup and access phase, response sampled in the access phase
  task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                          output apb_data_t rdata, output logic slverr);
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk);
    apb_req.penable = 1'b1;
    #1;
    check_bit(apb_rsp.pready, 1'b1, "pready");
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(negedge clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata);
    apb_data_t rdata;
    logic      slverr;
    apb_xfer(1'b1, addr, wdata, rdata, slverr);
    check_bit(slverr, 1'b0, "pslverr on write");
  endtask

  task automatic expect_reg(input apb_addr_t addr, input apb_data_t exp, input string what);
    apb_data_t rdata;
    logic      slverr;
    apb_xfer(1'b0, addr, '0, rdata, slverr);
    check_bit(slverr, 1'b0, "pslverr on read");
    check(64'(rdata), 64'(exp), what);
  endtask

  // Forms 0, 1, 2 are subgroups 40, 18 and 20
  task automatic aeg_write(input int form, input aeg_idx_t idx, input cae_data_t value);
    inst_t i;
    case (form)
      0: i = {3'($urandom), 4'b1101, 7'h40, idx};
      1: i = {3'($urandom), 5'b11100, 6'h18, idx[11:6], 6'($urandom), idx[5:0]};
      default: i = {3'($urandom), 5'b11100, 6'h20, idx[11:6], 6'($urandom), idx[5:0]};
    endcase
    issue(i, value);
    check_bit(rd_vld, 1'b0, "rd_vld after write");
    if (32'(idx) < AEG_CNT) begin
      model[int'(idx)] = value;
    end
  endtask

  // Forms 0, 1, 2 are subgroups 68, 70 and 1c
  task automatic aeg_read(input int form, input aeg_idx_t idx);
    inst_t     i;
    cae_data_t d;
    cae_data_t exp;
    d = {$urandom, $urandom};
    case (form)
      0: begin
        i = {3'($urandom), 4'b1101, 7'h68, 18'($urandom)};
        d[17:0] = idx;
      end
      1: i = {3'($urandom), 4'b1101, 7'h70, idx[11:0], 6'($urandom)};
      default: i = {3'($urandom), 5'b11101, 6'h1c, idx[11:0], 6'($urandom)};
    endcase
    exp = (32'(idx) < AEG_CNT) ? model[int'(idx)] : '0;
    issue(i, d);
    check_bit(rd_vld, 1'b1, "rd_vld after read");
    check(rd_data, exp, "rd_data");
  endtask

  task automatic wait_irq(input logic level, input int max_cyc);
    int n;
    n = 0;
    while (irq !== level && n < max_cyc) begin
      @(negedge clk);
      n++;
    end
    chk_cnt++;
    assert (irq === level) else begin
      $display("irq did not go to %0b within %0d cycles", level, max_cyc);
      err_cnt++;
    end
  endtask

  task automatic aeg_forms();
    int       start;
    int       k;
    aeg_idx_t idx;
    start = err_cnt;
    for (k = 0; k < 12; k++) begin
      idx = aeg_idx_t'($urandom_range(AEG_CNT - 1, 0));
      aeg_write(k % 3, idx, {$urandom, $urandom});
      aeg_read(k % 3, idx);
      aeg_read((k + 1) % 3, aeg_idx_t'($urandom_range(AEG_CNT - 1, 0)));
    end
    report("aeg_forms", start);
  endtask

  task automatic index_range();
    int start;
    int n;
    start = err_cnt;
    apb_write(REG_STATUS, 32'h3);
    aeg_write(0, aeg_idx_t'($urandom_range(32'h3ffff, AEG_CNT)), {$urandom, $urandom});
    aeg_write(1, aeg_idx_t'($urandom_range(4095, AEG_CNT)), {$urandom, $urandom});
    expect_reg(REG_STATUS, 32'h2, "STATUS after bad write");
    // No register may have been hit by the bad writes
    for (n = 0; n < AEG_CNT; n++) begin
      aeg_read(1, aeg_idx_t'(n));
    end
    apb_write(REG_STATUS, 32'h3);
    aeg_read(0, aeg_idx_t'($urandom_range(32'h3ffff, AEG_CNT)));
    expect_reg(REG_STATUS, 32'h2, "STATUS after bad read");
    report("index_range", start);
  endtask

  task automatic caep_dispatch();
    int    start;
    int    k;
    caep_t num;
    start = err_cnt;
    apb_write(REG_STATUS, 32'h3);
    for (k = 0; k < 8; k++) begin
      num = caep_t'($urandom);
      @(negedge clk);
      inst     = {3'($urandom), 5'b11110, 1'b1, num, 18'($urandom)};
      data     = {$urandom, $urandom};
      inst_vld = 1'b1;
      #1;
      check_bit(caep_vld, 1'b1, "caep_vld");
      check(64'(caep), 64'(num), "caep");
      @(negedge clk);
      inst_vld = 1'b0;
      check_bit(rd_vld, 1'b0, "rd_vld after CAEP");
      #1;
      check_bit(caep_vld, 1'b0, "caep_vld after strobe");
    end
    expect_reg(REG_STATUS, 32'h0, "STATUS after CAEP");
    report("caep_dispatch", start);
  endtask

  task automatic unimpl_insts();
    inst_t bad [7];
    int    start;
    int    k;
    start = err_cnt;
    bad[0] = {3'($urandom), 4'b1101, 7'h41, 18'($urandom)};
    bad[1] = {3'($urandom), 4'b1101, 7'h05, 18'($urandom)};
    bad[2] = {3'($urandom), 5'b11100, 6'h19, 18'($urandom)};
    bad[3] = {3'($urandom), 5'b11101, 6'h1d, 18'($urandom)};
    bad[4] = {3'($urandom), 5'b11110, 1'b0, 23'($urandom)};
    bad[5] = {3'($urandom), 5'b00110, 24'($urandom)};
    bad[6] = {3'($urandom), 5'b11111, 24'($urandom)};
    for (k = 0; k < 7; k++) begin
      apb_write(REG_STATUS, 32'h3);
      issue(bad[k], {$urandom, $urandom});
      expect_reg(REG_STATUS, 32'h1, "STATUS after unimplemented");
      expect_reg(REG_ERR_INST, bad[k], "ERR_INST");
    end
    apb_write(REG_STATUS, 32'h3);
    for (k = 0; k < 7; k++) begin
      issue(bad[k], {$urandom, $urandom});
    end
    expect_reg(REG_ERR_INST, bad[0], "ERR_INST after a burst");
    report("unimpl_insts", start);
  endtask

  task automatic irq_and_apb();
    int        start;
    apb_data_t rdata;
    logic      slverr;
    start = err_cnt;
    apb_write(REG_MASK, 32'h0);
    apb_write(REG_STATUS, 32'h3);
    aeg_read(2, aeg_idx_t'(AEG_CNT + 3));
    repeat (4) @(negedge clk);
    check_bit(irq, 1'b0, "irq with mask clear");
    expect_reg(REG_STATUS, 32'h2, "STATUS before mask");
    apb_write(REG_MASK, 32'h3);
    expect_reg(REG_MASK, 32'h3, "MASK");
    wait_irq(1'b1, 4);
    apb_write(REG_STATUS, 32'h3);
    wait_irq(1'b0, 4);
    expect_reg(REG_STATUS, 32'h0, "STATUS after clear");
    apb_xfer(1'b1, 8'h0c, 32'h0, rdata, slverr);
    check_bit(slverr, 1'b1, "pslverr on unmapped write");
    apb_xfer(1'b0, 8'h40, 32'h0, rdata, slverr);
    check_bit(slverr, 1'b1, "pslverr on unmapped read");
    expect_reg(REG_MASK, 32'h3, "MASK after unmapped write");
    apb_write(REG_MASK, 32'h0);
    report("irq_and_apb", start);
  endtask

  task automatic idle_port();
    int start;
    int k;
    start = err_cnt;
    apb_write(REG_STATUS, 32'h3);
    for (k = 0; k < 20; k++) begin
      @(negedge clk);
      inst     = $urandom;
      data     = {$urandom, $urandom};
      inst_vld = 1'b0;
      check_bit(rd_vld, 1'b0, "rd_vld while idle");
      #1;
      check_bit(caep_vld, 1'b0, "caep_vld while idle");
    end
    expect_reg(REG_STATUS, 32'h0, "STATUS after idle");
    report("idle_port", start);
  endtask

  initial begin
    void'($urandom(32'hb1c7));
    err_cnt  = 0;
    chk_cnt  = 0;
    test_cnt = 0;
    reset    = 1'b1;
    inst     = '0;
    data     = '0;
    inst_vld = 1'b0;
    apb_req  = '0;
    repeat (RESET_CYC) @(negedge clk);
    reset = 1'b0;
    aeg_forms();
    index_range();
    caep_dispatch();
    unimpl_insts();
    irq_and_apb();
    idle_port();
    // Decoder assertion failures count as errors too
    err_cnt += dut_i.instdec_chk_i.fail_cnt;
    $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: verification/instdec_chk.sv
// Decoder checker: action flag and CAEP field rules of the instruction decoder
`timescale 1ns/1ns

module instdec_chk import cae_isa_pkg::*; (
  input logic  clk,
  input logic  reset,
  input inst_t inst,
  input logic  inst_vld,
  input dec_t  dec
);

  logic [3:0] flags;

  // Number of failed assertions
  int fail_cnt = 0;

  assign flags = {dec.aeg_wr, dec.aeg_rd, dec.caep_vld, dec.unimpl};

  onehot_when_valid: assert property (
    @(posedge clk) disable iff (reset) inst_vld |-> $onehot(flags)
  ) else begin
    $error("decoder action flags not one-hot for a valid instruction");
    fail_cnt++;
  end

  quiet_when_idle: assert property (
    @(posedge clk) disable iff (reset) !inst_vld |-> (flags == 4'b0)
  ) else begin
    $error("decoder action flag set without a valid instruction");
    fail_cnt++;
  end

  rd_wr_exclusive: assert property (
    @(posedge clk) disable iff (reset) !(dec.aeg_wr && dec.aeg_rd)
  ) else begin
    $error("decoder flags an AEG read and write together");
    fail_cnt++;
  end

  // CAEP number only within group 11110
  caep_in_group: assert property (
    @(posedge clk) disable iff (reset) (inst[28:24] != GRP_11110) |-> (dec.caep == '0)
  ) else begin
    $error("decoder CAEP number nonzero outside group 11110");
    fail_cnt++;
  end

endmodule

bind cae_top instdec_chk instdec_chk_i (
  .clk      (clk),
  .reset    (reset),
  .inst     (inst),
  .inst_vld (inst_vld),
  .dec      (dec)
);

// File: design/cae_top.sv
// CAE front end top: host instruction port, decoder, AEG registers and status block
`timescale 1ns/1ns

module cae_top import cae_isa_pkg::*; import cae_reg_pkg::*; #(
  parameter int AEG_CNT = 16
) (
  input  logic      clk,
  input  logic      reset,
  input  inst_t     inst,
  input  cae_data_t data,
  input  logic      inst_vld,
  output logic      caep_vld,
  output caep_t     caep,
  output cae_data_t rd_data,
  output logic      rd_vld,
  input  apb_req_t  apb_req,
  output apb_rsp_t  apb_rsp,
  output logic      irq
);

  dec_t dec;
  logic range_err;
  err_t err;

  instdec instdec_i (
    .inst     (inst),
    .data     (data),
    .inst_vld (inst_vld),
    .dec      (dec)
  );

  aeg_regfile #(
    .AEG_CNT (AEG_CNT)
  ) aeg_regfile_i (
    .clk       (clk),
    .reset     (reset),
    .dec       (dec),
    .data      (data),
    .rd_data   (rd_data),
    .rd_vld    (rd_vld),
    .range_err (range_err)
  );

  // Exception events toward status
  assign err.unimpl    = dec.unimpl;
  assign err.idx_range = range_err;

  cae_status_apb cae_status_apb_i (
    .clk     (clk),
    .reset   (reset),
    .err     (err),
    .inst    (inst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .irq     (irq)
  );

  // CAEP dispatch goes straight out in the instruction cycle
  assign caep_vld = dec.caep_vld;
  assign caep     = dec.caep;

endmodule

// File: design/cae_status_apb.sv
// Exception status block: sticky error bits, interrupt mask and faulting instruction over APB
`timescale 1ns/1ns

module cae_status_apb import cae_isa_pkg::*; import cae_reg_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  err_t     err,
  input  inst_t    inst,
  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp,
  output logic     irq
);

  err_t      status;
  err_t      mask;
  inst_t     err_inst;

  logic      access;
  logic      wr_access;
  logic      addr_ok;
  err_t      clr;
  apb_data_t rsp_data;

  assign access    = apb_req.psel && apb_req.penable;
  assign wr_access = access && apb_req.pwrite;

  // Address decode and read mux
  always_comb begin
    addr_ok  = 1'b1;
    rsp_data = '0;
    case (apb_req.paddr)
      REG_STATUS: begin
        rsp_data[ERR_UNIMPL_BIT] = status.unimpl;
        rsp_data[ERR_RANGE_BIT]  = status.idx_range;
      end
      REG_MASK: begin
        rsp_data[ERR_UNIMPL_BIT] = mask.unimpl;
        rsp_data[ERR_RANGE_BIT]  = mask.idx_range;
      end
      REG_ERR_INST: rsp_data = err_inst;
      default: addr_ok = 1'b0;
    endcase
  end

  // Write one to clear
  always_comb begin
    clr = '0;
    if (wr_access && (apb_req.paddr == REG_STATUS)) begin
      clr.unimpl    = apb_req.pwdata[ERR_UNIMPL_BIT];
      clr.idx_range = apb_req.pwdata[ERR_RANGE_BIT];
    end
  end

  // New events win over a clear in the same cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      status <= '0;
    end else begin
      status <= (status & ~clr) | err;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mask <= '0;
    end else if (wr_access && (apb_req.paddr == REG_MASK)) begin
      mask.unimpl    <= apb_req.pwdata[ERR_UNIMPL_BIT];
      mask.idx_range <= apb_req.pwdata[ERR_RANGE_BIT];
    end
  end

  // Keeps only the first fault since status was clear
  always_ff @(posedge clk) begin
    if (reset) begin
      err_inst <= '0;
    end else if ((status == '0) && (err != '0)) begin
      err_inst <= inst;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      irq <= 1'b0;
    end else begin
      irq <= |(status & mask);
    end
  end

  // No wait states
  assign apb_rsp.prdata  = rsp_data;
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = access && !addr_ok;

endmodule

// File: design/aeg_regfile.sv
// AEG register file: 64-bit general registers with write, registered read and range check
`timescale 1ns/1ns

module aeg_regfile import cae_isa_pkg::*; #(
  parameter int AEG_CNT = 16
) (
  input  logic      clk,
  input  logic      reset,
  input  dec_t      dec,
  input  cae_data_t data,
  output cae_data_t rd_data,
  output logic      rd_vld,
  output logic      range_err
);

  // Select width, at least one bit for a single register
  localparam int SEL_W = (AEG_CNT > 1) ? $clog2(AEG_CNT) : 1;

  cae_data_t        regs [AEG_CNT];
  logic             in_range;
  logic [SEL_W-1:0] reg_sel;

  assign in_range = ({14'b0, dec.idx} < 32'(AEG_CNT));
  assign reg_sel  = dec.idx[SEL_W-1:0];

  // Flagged in the same cycle as the access
  assign range_err = (dec.aeg_wr || dec.aeg_rd) && !in_range;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < AEG_CNT; i++) begin
        regs[i] <= '0;
      end
    end else if (dec.aeg_wr && in_range) begin
      regs[reg_sel] <= data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_vld <= 1'b0;
    end else begin
      rd_vld <= dec.aeg_rd;
    end
  end

  // Out of range reads answer zero
  always_ff @(posedge clk) begin
    if (dec.aeg_rd) begin
      rd_data <= in_range ? regs[reg_sel] : '0;
    end
  end

endmodule

// File: design/instdec.sv
// Instruction decoder: classifies host instructions into AEG writes, AEG reads and CAEP dispatches
`timescale 1ns/1ns

module instdec import cae_isa_pkg::*; (
  input  inst_t     inst,
  input  cae_data_t data,
  input  logic      inst_vld,
  output dec_t      dec
);

  logic grp_1101x;
  logic grp_11100;
  logic grp_11101;
  logic grp_11110;

  logic wr_40;
  logic rd_68;
  logic rd_70;
  logic wr_18;
  logic wr_20;
  logic rd_1c;
  logic caep_hit;

  logic is_wr;
  logic is_rd;

  aeg_idx_t idx;

  // Major group match
  assign grp_1101x = (inst[28:25] == GRP_1101X);
  assign grp_11100 = (inst[28:24] == GRP_11100);
  assign grp_11101 = (inst[28:24] == GRP_11101);
  assign grp_11110 = (inst[28:24] == GRP_11110);

  // 1101x uses the 7-bit subgroup including bit 24
  assign wr_40 = grp_1101x && (inst[24:18] == SUB_WR_IMM);
  assign rd_68 = grp_1101x && (inst[24:18] == SUB_RD_DATA);
  assign rd_70 = grp_1101x && (inst[24:18] == SUB_RD_FLD);

  assign wr_18 = grp_11100 && (inst[23:18] == SUB_WR_18);
  assign wr_20 = grp_11100 && (inst[23:18] == SUB_WR_20);
  assign rd_1c = grp_11101 && (inst[23:18] == SUB_RD_1C);

  assign caep_hit = grp_11110 && inst[CAEP_QUAL_BIT];

  assign is_wr = wr_40 | wr_18 | wr_20;
  assign is_rd = rd_68 | rd_70 | rd_1c;

  // Index extraction per form, zero for forms without an index
  always_comb begin
    idx = '0;
    if (wr_40) begin
      idx = inst[17:0];
    end else if (rd_68) begin
      idx = data[17:0];
    end else if (rd_70 || rd_1c) begin
      idx = {6'b0, inst[17:6]};
    end else if (wr_18 || wr_20) begin
      idx = {6'b0, inst[17:12], inst[5:0]};
    end
  end

  always_comb begin
    dec.aeg_wr   = inst_vld && is_wr;
    dec.aeg_rd   = inst_vld && is_rd;
    dec.caep_vld = inst_vld && caep_hit;
    // Anything not recognized above is an exception
    dec.unimpl   = inst_vld && !(is_wr || is_rd || caep_hit);
    // CAEP number shown for the whole group, valid or not
    dec.caep     = grp_11110 ? inst[22:18] : '0;
    dec.idx      = idx;
  end

endmodule

// File: design/cae_reg_pkg.sv
// CAE register bus package: APB request and response, status layout and register map
package cae_reg_pkg;

  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

  // Exception bits, same layout for status, mask and set events
  typedef struct packed {
    logic idx_range;
    logic unimpl;
  } err_t;

  localparam int ERR_UNIMPL_BIT = 0;
  localparam int ERR_RANGE_BIT  = 1;

  localparam apb_addr_t REG_STATUS   = 8'h00;
  localparam apb_addr_t REG_MASK     = 8'h04;
  localparam apb_addr_t REG_ERR_INST = 8'h08;

endpackage

// File: design/cae_isa_pkg.sv
// CAE instruction set package: instruction, data and index types, decoder output, opcode fields
package cae_isa_pkg;

  typedef logic [31:0] inst_t;
  typedef logic [63:0] cae_data_t;
  typedef logic [17:0] aeg_idx_t;
  typedef logic [4:0]  caep_t;

  // Decoder output, one action flag per class plus its operands
  typedef struct packed {
    logic     aeg_wr;
    logic     aeg_rd;
    logic     caep_vld;
    logic     unimpl;
    caep_t    caep;
    aeg_idx_t idx;
  } dec_t;

  // Major groups, bits 28:24 (1101x matched on bits 28:25)
  localparam logic [3:0] GRP_1101X = 4'b1101;
  localparam logic [4:0] GRP_11100 = 5'b11100;
  localparam logic [4:0] GRP_11101 = 5'b11101;
  localparam logic [4:0] GRP_11110 = 5'b11110;

  // Group 1101x subgroups, bits 24:18
  localparam logic [6:0] SUB_WR_IMM  = 7'h40;
  localparam logic [6:0] SUB_RD_DATA = 7'h68;
  localparam logic [6:0] SUB_RD_FLD  = 7'h70;

  // Group 11100 and 11101 subgroups, bits 23:18
  localparam logic [5:0] SUB_WR_18 = 6'h18;
  localparam logic [5:0] SUB_WR_20 = 6'h20;
  localparam logic [5:0] SUB_RD_1C = 6'h1c;

  // Group 11110 dispatch qualifier
  localparam int CAEP_QUAL_BIT = 23;

endpackage
